// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - design
    files:
      - design/dcache_pkg.sv
      - design/dcache_tag_array.sv
      - design/dcache_data_array.sv
      - design/dcache_miss_ctrl.sv
      - design/dcache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/dcache_props.sv
      - tests/dcache_tb.sv

// File: design/dcache_data_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_data_array (
    input  logic                                clk,
    input  logic                                a_en,
    input  logic [`DC_DATA_ADDR_BITS-1:0]       a_addr,
    input  dcache_pkg::strobe_t                 a_strobe,
    input  dcache_pkg::word_t                   a_wdata,
    output dcache_pkg::word_t                   a_rdata,
    input  logic                                b_en,
    input  logic [`DC_DATA_ADDR_BITS-1:0]       b_addr,
    input  dcache_pkg::strobe_t                 b_strobe,
    input  dcache_pkg::word_t                   b_wdata,
    output dcache_pkg::word_t                   b_rdata
);

    dcache_pkg::word_t mem [1 << `DC_DATA_ADDR_BITS];

    // both ports share one process so reads see the old word
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
            for (int i = 0; i < `DC_STROBE_BITS; i++) begin
                if (a_strobe[i]) begin
                    mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
                end
            end
        end
        if (b_en) begin
            b_rdata <= mem[b_addr];
            for (int i = 0; i < `DC_STROBE_BITS; i++) begin
                if (b_strobe[i]) begin
                    mem[b_addr][8*i +: 8] <= b_wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_miss_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_miss_ctrl (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            req_valid,
    input  dcache_pkg::index_t              req_index,
    input  dcache_pkg::tag_t                req_tag,
    input  logic                            hit,
    input  dcache_pkg::way_t                victim_way,
    input  dcache_pkg::tag_t                victim_tag,
    input  logic                            victim_dirty,
    output logic                            idle,
    output logic                            fill_en,
    output dcache_pkg::way_t                fill_way,
    output dcache_pkg::tag_t                fill_tag,
    output logic                            b_en,
    output logic [`DC_DATA_ADDR_BITS-1:0]   b_addr,
    output dcache_pkg::strobe_t             b_strobe,
    output dcache_pkg::word_t               b_wdata,
    input  dcache_pkg::word_t               b_rdata,
    output logic                            mem_valid,
    output logic                            mem_is_write,
    output logic [31:0]                     mem_addr,
    output dcache_pkg::word_t               mem_wdata,
    input  logic                            mem_ready,
    input  logic                            mem_last,
    input  dcache_pkg::word_t               mem_rdata
);

    // offset and byte bits below the line address
    localparam int LINE_LSB = `DC_OFFSET_BITS + 2;

    dcache_pkg::miss_state_t state;

    dcache_pkg::way_t miss_way;
    dcache_pkg::index_t miss_index;
    dcache_pkg::tag_t miss_tag;
    dcache_pkg::tag_t wb_tag;

    dcache_pkg::offset_t beat;
    // one extra bit so the drain can run 17 cycles
    logic [`DC_OFFSET_BITS:0] drain_cnt;
    dcache_pkg::offset_t drain_prev;

    dcache_pkg::word_t line_buf [`DC_WORDS_PER_LINE];

    logic miss_start;

    assign idle = (state == dcache_pkg::IDLE);
    assign miss_start = idle & req_valid & ~hit;
    assign drain_prev = dcache_pkg::offset_t'(drain_cnt - 1'b1);

    assign fill_way = miss_way;
    assign fill_tag = miss_tag;
    assign b_wdata = mem_rdata;
    assign mem_wdata = line_buf[beat];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= dcache_pkg::IDLE;
            beat <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    if (miss_start) begin
                        state <= victim_dirty ? dcache_pkg::DRAIN : dcache_pkg::FETCH;
                        beat <= '0;
                        drain_cnt <= '0;
                    end
                end
                dcache_pkg::DRAIN: begin
                    if (drain_cnt == (`DC_OFFSET_BITS+1)'(`DC_WORDS_PER_LINE)) begin
                        state <= dcache_pkg::WRITEBACK;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                dcache_pkg::WRITEBACK: begin
                    if (mem_ready) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= dcache_pkg::FETCH;
                            beat <= '0;
                        end
                    end
                end
                dcache_pkg::FETCH: begin
                    if (mem_ready) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= dcache_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    state <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

    // miss context held for the whole miss
    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_way <= victim_way;
            miss_index <= req_index;
            miss_tag <= req_tag;
            wb_tag <= victim_tag;
        end
    end

    // victim words land one cycle after their read
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::DRAIN && drain_cnt != '0) begin
            line_buf[drain_prev] <= b_rdata;
        end
    end

    always_comb begin
        mem_valid = 1'b0;
        mem_is_write = 1'b0;
        mem_addr = '0;
        b_en = 1'b0;
        b_addr = {miss_way, miss_index, beat};
        b_strobe = '0;
        fill_en = 1'b0;
        case (state)
            dcache_pkg::DRAIN: begin
                b_en = ~drain_cnt[`DC_OFFSET_BITS];
                b_addr = {miss_way, miss_index, drain_cnt[`DC_OFFSET_BITS-1:0]};
            end
            dcache_pkg::WRITEBACK: begin
                mem_valid = 1'b1;
                mem_is_write = 1'b1;
                mem_addr = {wb_tag, miss_index, {LINE_LSB{1'b0}}};
            end
            dcache_pkg::FETCH: begin
                mem_valid = 1'b1;
                mem_addr = {miss_tag, miss_index, {LINE_LSB{1'b0}}};
                // refill word goes straight into the array
                b_en = mem_ready;
                b_strobe = '1;
                fill_en = mem_ready & mem_last;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// line geometry
`define DC_WORDS_PER_LINE 16
`define DC_WAYS 2
`define DC_SETS 128

// address split into tag, index, word offset and byte select
`define DC_OFFSET_BITS 4
`define DC_INDEX_BITS 7
`define DC_TAG_BITS 19

// word and byte lanes
`define DC_WORD_BITS 32
`define DC_STROBE_BITS 4

// data array address is way, index, offset
`define DC_DATA_ADDR_BITS 12

`endif

// File: design/dcache_pkg.sv
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    // miss sequencing
    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        WRITEBACK,
        FETCH
    } miss_state_t;

    // address fields
    typedef logic [`DC_TAG_BITS-1:0] tag_t;
    typedef logic [`DC_INDEX_BITS-1:0] index_t;
    typedef logic [`DC_OFFSET_BITS-1:0] offset_t;
    typedef logic way_t;

    // data path
    typedef logic [`DC_WORD_BITS-1:0] word_t;
    typedef logic [`DC_STROBE_BITS-1:0] strobe_t;

endpackage

`default_nettype wire

// File: design/dcache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_tag_array (
    input  logic                 clk,
    input  logic                 resetn,
    input  dcache_pkg::index_t   lookup_index,
    input  dcache_pkg::tag_t     lookup_tag,
    input  logic                 hit_write,
    input  logic                 hit_accept,
    input  logic                 fill_en,
    input  dcache_pkg::way_t     fill_way,
    input  dcache_pkg::tag_t     fill_tag,
    output logic                 hit,
    output dcache_pkg::way_t     hit_way,
    output dcache_pkg::way_t     victim_way,
    output dcache_pkg::tag_t     victim_tag,
    output logic                 victim_dirty
);

    dcache_pkg::tag_t tags [`DC_WAYS][`DC_SETS];

    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty;

    // per set, points at the least recently used way
    logic [`DC_SETS-1:0] lru;

    // parallel compare over all ways of the set
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (valid[w][lookup_index] && tags[w][lookup_index] == lookup_tag) begin
                hit = 1'b1;
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign victim_way = lru[lookup_index];
    assign victim_tag = tags[victim_way][lookup_index];
    // clean or empty lines never need a writeback
    assign victim_dirty = valid[victim_way][lookup_index] & dirty[victim_way][lookup_index];

    // tag storage
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_way][lookup_index] <= fill_tag;
        end
    end

    // line state bits
    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
            dirty <= '0;
            lru <= '0;
        end else begin
            if (fill_en) begin
                valid[fill_way][lookup_index] <= 1'b1;
                dirty[fill_way][lookup_index] <= 1'b0;
            end
            if (hit_accept) begin
                lru[lookup_index] <= ~hit_way;
                if (hit_write) begin
                    dirty[hit_way][lookup_index] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    req_valid,
    input  logic [31:0]             req_addr,
    input  dcache_pkg::strobe_t     req_strobe,
    input  dcache_pkg::word_t       req_data,
    output logic                    addr_ok,
    output logic                    data_ok,
    output dcache_pkg::word_t       resp_data,
    output logic                    mem_valid,
    output logic                    mem_is_write,
    output logic [31:0]             mem_addr,
    output dcache_pkg::word_t       mem_wdata,
    input  logic                    mem_ready,
    input  logic                    mem_last,
    input  dcache_pkg::word_t       mem_rdata
);

    dcache_pkg::tag_t req_tag;
    dcache_pkg::index_t req_index;
    dcache_pkg::offset_t req_offset;

    logic hit;
    dcache_pkg::way_t hit_way;
    dcache_pkg::way_t victim_way;
    dcache_pkg::tag_t victim_tag;
    logic victim_dirty;

    logic idle;
    logic fill_en;
    dcache_pkg::way_t fill_way;
    dcache_pkg::tag_t fill_tag;

    logic b_en;
    logic [`DC_DATA_ADDR_BITS-1:0] b_addr;
    dcache_pkg::strobe_t b_strobe;
    dcache_pkg::word_t b_wdata;
    dcache_pkg::word_t b_rdata;

    // tag | index | word offset | byte select
    assign req_tag = req_addr[31 -: `DC_TAG_BITS];
    assign req_index = req_addr[`DC_OFFSET_BITS+2 +: `DC_INDEX_BITS];
    assign req_offset = req_addr[2 +: `DC_OFFSET_BITS];

    // hits are only served while no miss is in flight
    assign addr_ok = req_valid & idle & hit;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok;
        end
    end

    dcache_tag_array u_tag_array (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_index (req_index),
        .lookup_tag   (req_tag),
        .hit_write    (|req_strobe),
        .hit_accept   (addr_ok),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    // port a serves hits, port b belongs to the miss controller
    dcache_data_array u_data_array (
        .clk      (clk),
        .a_en     (addr_ok),
        .a_addr   ({hit_way, req_index, req_offset}),
        .a_strobe (req_strobe),
        .a_wdata  (req_data),
        .a_rdata  (resp_data),
        .b_en     (b_en),
        .b_addr   (b_addr),
        .b_strobe (b_strobe),
        .b_wdata  (b_wdata),
        .b_rdata  (b_rdata)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .hit          (hit),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .idle         (idle),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .b_en         (b_en),
        .b_addr       (b_addr),
        .b_strobe     (b_strobe),
        .b_wdata      (b_wdata),
        .b_rdata      (b_rdata),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// File: tests/dcache_props.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_props (
    input  logic                clk,
    input  logic                resetn,
    input  logic                req_valid,
    input  logic                addr_ok,
    input  logic                data_ok,
    input  logic                mem_valid,
    input  logic                mem_is_write,
    input  logic [31:0]         mem_addr,
    input  dcache_pkg::word_t   mem_wdata,
    input  logic                mem_ready
);

    int unsigned fail_count;
    // goes high once a request has been refused
    logic missed;

    initial fail_count = 0;

    always_ff @(posedge clk) begin
        if (resetn) begin
            missed <= 1'b0;
        end else if (req_valid && !addr_ok) begin
            missed <= 1'b1;
        end
    end

    no_mem_before_miss: assert property (
        @(posedge clk) disable iff (resetn) !missed |-> !mem_valid
    ) else begin
        fail_count++;
        $error("mem_valid raised before any miss");
    end

    data_ok_follows: assert property (
        @(posedge clk) disable iff (resetn) data_ok == $past(addr_ok)
    ) else begin
        fail_count++;
        $error("data_ok not one cycle after addr_ok");
    end

    // back-pressure holds the whole beat
    mem_hold: assert property (
        @(posedge clk) disable iff (resetn) mem_valid && !mem_ready |=>
            mem_valid && $stable(mem_is_write) && $stable(mem_addr) && $stable(mem_wdata)
    ) else begin
        fail_count++;
        $error("memory outputs changed while stalled");
    end

endmodule

bind dcache_top dcache_props u_props (
    .clk          (clk),
    .resetn       (resetn),
    .req_valid    (req_valid),
    .addr_ok      (addr_ok),
    .data_ok      (data_ok),
    .mem_valid    (mem_valid),
    .mem_is_write (mem_is_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ready    (mem_ready)
);

`default_nettype wire

// File: tests/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int LINE_LSB = `DC_OFFSET_BITS + 2;

    logic clk;
    logic resetn;
    logic req_valid;
    logic [31:0] req_addr;
    dcache_pkg::strobe_t req_strobe;
    dcache_pkg::word_t req_data;
    logic addr_ok;
    logic data_ok;
    dcache_pkg::word_t resp_data;
    logic mem_valid;
    logic mem_is_write;
    logic [31:0] mem_addr;
    dcache_pkg::word_t mem_wdata;
    logic mem_ready;
    logic mem_last;
    dcache_pkg::word_t mem_rdata;

    // backing memory, and the value every word should read as
    dcache_pkg::word_t mem_words [logic [31:0]];
    dcache_pkg::word_t shadow [logic [31:0]];
    dcache_pkg::word_t expected_q [$];

    string test_name;
    int rd_bursts;
    int wb_bursts;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wb_addr;

    dcache_top u_dcache_top (.*);

    always #2 clk = ~clk;

    // untouched memory words are a hash of their byte address
    function automatic dcache_pkg::word_t fill_word(logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h6a09e667;
    endfunction

    function automatic logic [31:0] line_of(logic [31:0] addr);
        return {addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
    endfunction

    function automatic logic [31:0] make_addr(dcache_pkg::tag_t t, dcache_pkg::index_t i,
                                              dcache_pkg::offset_t o);
        return {t, i, o, 2'b00};
    endfunction

    function automatic dcache_pkg::word_t ref_read(logic [31:0] addr);
        if (shadow.exists(addr)) return shadow[addr];
        return fill_word(addr);
    endfunction

    function automatic dcache_pkg::word_t mem_read(logic [31:0] addr);
        if (mem_words.exists(addr)) return mem_words[addr];
        return fill_word(addr);
    endfunction

    // byte merge of a write into the expected view
    function automatic void ref_write(logic [31:0] addr, dcache_pkg::strobe_t strobe,
                                      dcache_pkg::word_t data);
        dcache_pkg::word_t w;
        w = ref_read(addr);
        for (int i = 0; i < `DC_STROBE_BITS; i++) begin
            if (strobe[i]) w[8*i +: 8] = data[8*i +: 8];
        end
        shadow[addr] = w;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string what, dcache_pkg::word_t exp, dcache_pkg::word_t act);
        if (act !== exp) begin
            fail_run($sformatf("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_line_addr(string what, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act));
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            fail_run($sformatf("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act));
        end
    endtask

    // holds the request until addr_ok, then queues the expected response
    task automatic access(logic [31:0] addr, dcache_pkg::strobe_t strobe,
                          dcache_pkg::word_t data);
        int waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        req_valid = 1'b1;
        req_addr = addr;
        req_strobe = strobe;
        req_data = data;
        while (!accepted) begin
            @(negedge clk);
            if (addr_ok === 1'b1) begin
                accepted = 1'b1;
                expected_q.push_back(ref_read(addr));
                if (strobe != '0) ref_write(addr, strobe, data);
            end else begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    fail_run($sformatf("request to %h was never accepted", addr));
                end
            end
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_run("responses still outstanding at timeout");
        end
    endtask

    // burst responder with random stalls and beats in word order
    initial begin : mem_responder
        int beats;
        logic [31:0] burst_addr;
        logic [31:0] beat_addr;
        logic beat_done;
        beats = 0;
        burst_addr = '0;
        forever begin
            @(negedge clk);
            beat_done = mem_valid && mem_ready;
            if (beats != 0 && mem_valid !== 1'b1) begin
                fail_run($sformatf("memory burst dropped after %0d beats", beats));
            end
            if (beats != 0 && mem_addr !== burst_addr) fail_run("mem_addr moved inside a burst");
            if (beat_done) begin
                if (beats == 0) begin
                    burst_addr = mem_addr;
                    check_line_addr("burst alignment", line_of(mem_addr), mem_addr);
                end
                beat_addr = mem_addr + 32'(beats * 4);
                if (mem_is_write) begin
                    check_word("writeback data", ref_read(beat_addr), mem_wdata);
                    mem_words[beat_addr] = mem_wdata;
                end
                beats++;
                if (beats == `DC_WORDS_PER_LINE) begin
                    beats = 0;
                    if (mem_is_write) begin
                        wb_bursts++;
                        last_wb_addr = burst_addr;
                    end else begin
                        rd_bursts++;
                        last_rd_addr = burst_addr;
                    end
                end
            end
            @(posedge clk);
            #1;
            mem_ready = ($urandom_range(0, 3) != 0);
            mem_last = (beats == `DC_WORDS_PER_LINE - 1);
            mem_rdata = mem_read(mem_addr + 32'(beats * 4));
        end
    end

    initial begin : compare_responses
        dcache_pkg::word_t expected;
        forever begin
            @(negedge clk);
            if (data_ok === 1'b1) begin
                if (expected_q.size() == 0) fail_run("data_ok with no request outstanding");
                expected = expected_q.pop_front();
                check_word("response data", expected, resp_data);
            end
        end
    end

    initial begin : main_sequence
        logic [31:0] addr_a;
        int rd_before;
        int wb_before;
        dcache_pkg::tag_t tag;
        dcache_pkg::index_t index;
        dcache_pkg::strobe_t strobe;
        void'($urandom(32'h56cf7cba));
        clk = 1'b0;
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_strobe = '0;
        req_data = '0;
        mem_ready = 1'b0;
        mem_last = 1'b0;
        mem_rdata = '0;
        rd_bursts = 0;
        wb_bursts = 0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b0;

        test_name = "idle_after_reset";
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            check_flag("addr_ok", 1'b0, addr_ok);
            check_flag("data_ok", 1'b0, data_ok);
            check_flag("mem_valid", 1'b0, mem_valid);
        end
        @(posedge clk);
        #1;

        test_name = "read_miss_fill";
        addr_a = make_addr(19'h00011, 7'd5, 4'd3);
        access(addr_a, '0, '0);
        check_count("read bursts", 1, rd_bursts);
        check_line_addr("fetch line", line_of(addr_a), last_rd_addr);
        for (int o = 0; o < `DC_WORDS_PER_LINE; o += 5) begin
            access(make_addr(19'h00011, 7'd5, dcache_pkg::offset_t'(o)), '0, '0);
        end
        check_count("read bursts on hits", 1, rd_bursts);

        test_name = "partial_write_hit";
        access(addr_a, 4'b0101, 32'hc0de_beef);
        access(addr_a, '0, '0);
        drain_responses();

        // set 5 now holds a dirty line in way 0 and nothing in way 1
        test_name = "lru_evict_dirty";
        access(make_addr(19'h00022, 7'd5, 4'd0), '0, '0);
        wb_before = wb_bursts;
        access(make_addr(19'h00033, 7'd5, 4'd7), '0, '0);
        check_count("writeback bursts", wb_before + 1, wb_bursts);
        check_line_addr("writeback line", line_of(addr_a), last_wb_addr);
        rd_before = rd_bursts;
        access(make_addr(19'h00022, 7'd5, 4'd9), '0, '0);
        check_count("read bursts on hit", rd_before, rd_bursts);
        access(addr_a, '0, '0);
        drain_responses();

        test_name = "random_traffic";
        for (int n = 0; n < 300; n++) begin
            tag = 19'h00040 + dcache_pkg::tag_t'($urandom_range(0, 3));
            index = 7'd8 + dcache_pkg::index_t'($urandom_range(0, 2));
            strobe = ($urandom_range(0, 1) == 0) ? '0 : 4'($urandom_range(1, 15));
            addr_a = make_addr(tag, index, 4'($urandom_range(0, 15)));
            access(addr_a, strobe, $urandom);
        end
        drain_responses();
        repeat (4) @(posedge clk);

        if (u_dcache_top.u_props.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/dcache_pkg.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_miss_ctrl.sv
design/dcache_top.sv
tests/dcache_props.sv
tests/dcache_tb.sv
